// File: hdl/usb_bulk_pkg.sv
package usb_bulk_pkg;

  // bus byte and endpoint number
  typedef logic [7:0] byte_t;
  typedef logic [3:0] endpt_t;

  // data PIDs, check nibble in the upper half
  typedef enum logic [7:0] {
    PID_DATA0 = 8'hC3,
    PID_DATA1 = 8'h4B
  } pid_e;

  localparam endpt_t USER_EP      = 4'd1;  // user byte stream
  localparam endpt_t TELEMETRY_EP = 4'd2;  // counter snapshot

  // telemetry record
  typedef logic [15:0] event_count_t;

  // sof, crc error, timeout; each low byte first
  localparam int unsigned TELE_RECORD_LEN = 6;

  // data packet crc16, shifted lsb first
  typedef logic [15:0] crc16_t;

  localparam crc16_t CRC16_POLY_REFL = 16'hA001;
  localparam crc16_t CRC16_INIT      = 16'hFFFF;

  // framer sequence: pid, payload, then crc low and high bytes
  typedef enum logic [2:0] {
    FS_IDLE,
    FS_PID,
    FS_PAYLOAD,
    FS_CRC_LO,
    FS_CRC_HI
  } frame_state_e;

endpackage

// File: hdl/in_endpoint_select.sv
module in_endpoint_select (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  blk_start_i,
  input  usb_bulk_pkg::endpt_t  blk_endpt_i,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  usb_bulk_pkg::byte_t   s_tdata_i,
  input  logic                  tel_tvalid_i,
  output logic                  tel_tready_o,
  input  logic                  tel_tlast_i,
  input  usb_bulk_pkg::byte_t   tel_tdata_i,
  output logic                  mux_tvalid_o,
  input  logic                  mux_tready_i,
  output logic                  mux_tlast_o,
  output usb_bulk_pkg::byte_t   mux_tdata_o,
  output logic                  xfer_start_o,
  output logic                  xfer_tele_o,
  output logic                  tele_start_o
);
  import usb_bulk_pkg::*;

  logic ep_user, ep_tele;
  logic sel_user_q, sel_tele_q;  // nothing selected out of reset

  assign ep_user = (blk_endpt_i == USER_EP);
  assign ep_tele = (blk_endpt_i == TELEMETRY_EP);

  // unknown endpoints never start a transfer
  assign xfer_start_o = blk_start_i & (ep_user | ep_tele);
  assign xfer_tele_o  = ep_tele;  // qualified by xfer_start_o
  assign tele_start_o = blk_start_i & ep_tele;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      sel_user_q <= 1'b0;
      sel_tele_q <= 1'b0;
    end else if (xfer_start_o) begin
      sel_user_q <= ep_user;
      sel_tele_q <= ep_tele;
    end
  end

  // steer the selected source into the skid buffer
  always_comb begin
    mux_tvalid_o = 1'b0;
    mux_tlast_o  = 1'b0;
    mux_tdata_o  = s_tdata_i;
    if (sel_tele_q) begin
      mux_tvalid_o = tel_tvalid_i;
      mux_tlast_o  = tel_tlast_i;
      mux_tdata_o  = tel_tdata_i;
    end else if (sel_user_q) begin
      mux_tvalid_o = s_tvalid_i;
      mux_tlast_o  = s_tlast_i;
    end
  end

  assign s_tready_o   = sel_user_q & mux_tready_i;
  assign tel_tready_o = sel_tele_q & mux_tready_i;

endmodule

// File: hdl/telemetry_capture.sv
module telemetry_capture (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 sof_i,
  input  logic                 crc_err_i,
  input  logic                 timeout_i,
  input  logic                 tele_start_i,
  output logic                 tel_tvalid_o,
  input  logic                 tel_tready_i,
  output logic                 tel_tlast_o,
  output usb_bulk_pkg::byte_t  tel_tdata_o,
  output logic                 has_telemetry_o
);
  import usb_bulk_pkg::*;

  localparam int unsigned IDX_W = $clog2(TELE_RECORD_LEN);

  event_count_t sof_cnt_q, crc_cnt_q, tmo_cnt_q;

  byte_t            snap_q [TELE_RECORD_LEN];
  logic [IDX_W-1:0] rec_idx_q;
  logic             rec_busy_q;  // record pending or streaming
  logic             rec_fire;

  // live counters
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      sof_cnt_q <= '0;
      crc_cnt_q <= '0;
      tmo_cnt_q <= '0;
    end else if (tele_start_i) begin
      // new period, a same-cycle event counts here
      sof_cnt_q <= event_count_t'(sof_i);
      crc_cnt_q <= event_count_t'(crc_err_i);
      tmo_cnt_q <= event_count_t'(timeout_i);
    end else begin
      sof_cnt_q <= sof_cnt_q + event_count_t'(sof_i);  // wraps at 16 bits
      crc_cnt_q <= crc_cnt_q + event_count_t'(crc_err_i);
      tmo_cnt_q <= tmo_cnt_q + event_count_t'(timeout_i);
    end
  end

  assign has_telemetry_o = (sof_cnt_q != '0) | (crc_cnt_q != '0) | (tmo_cnt_q != '0);

  // snapshot in record order
  always_ff @(posedge clock) begin
    if (tele_start_i) begin
      snap_q[0] <= sof_cnt_q[7:0];
      snap_q[1] <= sof_cnt_q[15:8];
      snap_q[2] <= crc_cnt_q[7:0];
      snap_q[3] <= crc_cnt_q[15:8];
      snap_q[4] <= tmo_cnt_q[7:0];
      snap_q[5] <= tmo_cnt_q[15:8];
    end
  end

  assign rec_fire = rec_busy_q & tel_tready_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rec_busy_q <= 1'b0;
      rec_idx_q  <= '0;
    end else if (tele_start_i) begin
      rec_busy_q <= 1'b1;
      rec_idx_q  <= '0;
    end else if (rec_fire) begin
      if (tel_tlast_o) begin
        rec_busy_q <= 1'b0;
      end
      rec_idx_q <= rec_idx_q + 1'b1;
    end
  end

  assign tel_tvalid_o = rec_busy_q;
  assign tel_tdata_o  = snap_q[rec_idx_q];
  assign tel_tlast_o  = (rec_idx_q == IDX_W'(TELE_RECORD_LEN - 1));  // sixth byte

endmodule

// File: hdl/axis_skid.sv
module axis_skid (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 s_tvalid_i,
  output logic                 s_tready_o,
  input  logic                 s_tlast_i,
  input  usb_bulk_pkg::byte_t  s_tdata_i,
  output logic                 m_tvalid_o,
  input  logic                 m_tready_i,
  output logic                 m_tlast_o,
  output usb_bulk_pkg::byte_t  m_tdata_o
);
  import usb_bulk_pkg::*;

  logic  out_valid_q, out_last_q;
  byte_t out_data_q;
  logic  sk_valid_q, sk_last_q;  // skid register
  byte_t sk_data_q;
  logic  in_fire, out_load;

  assign s_tready_o = ~sk_valid_q;  // full once the skid holds a byte
  assign in_fire    = s_tvalid_i & s_tready_o;
  assign out_load   = m_tready_i | ~out_valid_q;  // output reg free next cycle

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      out_valid_q <= 1'b0;
      sk_valid_q  <= 1'b0;
    end else if (out_load) begin
      out_valid_q <= sk_valid_q | in_fire;
      sk_valid_q  <= 1'b0;
    end else if (in_fire) begin
      sk_valid_q <= 1'b1;  // output stalled, park the byte
    end
  end

  always_ff @(posedge clock) begin
    if (out_load) begin
      if (sk_valid_q) begin
        out_last_q <= sk_last_q;
        out_data_q <= sk_data_q;
      end else begin
        out_last_q <= s_tlast_i;
        out_data_q <= s_tdata_i;
      end
    end
    if (in_fire) begin
      sk_last_q <= s_tlast_i;
      sk_data_q <= s_tdata_i;
    end
  end

  assign m_tvalid_o = out_valid_q;
  assign m_tlast_o  = out_last_q;
  assign m_tdata_o  = out_data_q;

endmodule

// File: hdl/data_packetizer.sv
module data_packetizer (
  input  logic                 clock,
  input  logic                 areset_n,
  input  logic                 xfer_start_i,
  input  logic                 xfer_tele_i,
  input  logic                 ack_i,
  input  logic                 s_tvalid_i,
  output logic                 s_tready_o,
  input  logic                 s_tlast_i,
  input  usb_bulk_pkg::byte_t  s_tdata_i,
  output logic                 tx_tvalid_o,
  input  logic                 tx_tready_i,
  output logic                 tx_tlast_o,
  output usb_bulk_pkg::byte_t  tx_tdata_o
);
  import usb_bulk_pkg::*;

  frame_state_e state_q, state_d;

  logic   [1:0] toggle_q;  // index 0 user, index 1 telemetry
  logic         pkt_tele_q;  // endpoint of the current or last packet
  crc16_t       crc_q;
  logic         pay_fire;
  pid_e         pid;

  // one payload byte through the reflected crc16
  function automatic crc16_t crc16_byte(input crc16_t crc, input byte_t data);
    crc16_t c;
    c = crc ^ crc16_t'(data);
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC16_POLY_REFL) : (c >> 1);
    end
    return c;
  endfunction

  assign pid      = toggle_q[pkt_tele_q] ? PID_DATA1 : PID_DATA0;
  assign pay_fire = (state_q == FS_PAYLOAD) & s_tvalid_i & tx_tready_i;

  always_comb begin
    state_d     = state_q;
    tx_tvalid_o = 1'b0;
    tx_tlast_o  = 1'b0;
    tx_tdata_o  = s_tdata_i;
    s_tready_o  = 1'b0;
    case (state_q)
      FS_IDLE: begin
        if (xfer_start_i) begin
          state_d = FS_PID;
        end
      end
      FS_PID: begin
        tx_tvalid_o = 1'b1;
        tx_tdata_o  = byte_t'(pid);
        if (tx_tready_i) begin
          state_d = FS_PAYLOAD;
        end
      end
      FS_PAYLOAD: begin
        // pass-through, the skid buffer holds the byte on a stall
        tx_tvalid_o = s_tvalid_i;
        s_tready_o  = tx_tready_i;
        if (pay_fire && s_tlast_i) begin
          state_d = FS_CRC_LO;
        end
      end
      FS_CRC_LO: begin
        tx_tvalid_o = 1'b1;
        tx_tdata_o  = ~crc_q[7:0];
        if (tx_tready_i) begin
          state_d = FS_CRC_HI;
        end
      end
      FS_CRC_HI: begin
        tx_tvalid_o = 1'b1;
        tx_tlast_o  = 1'b1;
        tx_tdata_o  = ~crc_q[15:8];
        if (tx_tready_i) begin
          state_d = FS_IDLE;
        end
      end
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q    <= FS_IDLE;
      toggle_q   <= 2'b00;  // both DATA0
      pkt_tele_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == FS_IDLE && xfer_start_i) begin
        pkt_tele_q <= xfer_tele_i;
      end
      if (ack_i) begin
        toggle_q[pkt_tele_q] <= ~toggle_q[pkt_tele_q];
      end
    end
  end

  // crc over the payload only
  always_ff @(posedge clock) begin
    if (state_q == FS_IDLE && xfer_start_i) begin
      crc_q <= CRC16_INIT;
    end else if (pay_fire) begin
      crc_q <= crc16_byte(crc_q, s_tdata_i);
    end
  end

endmodule

// File: hdl/bulk_in_path.sv
module bulk_in_path (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  blk_start_i,
  input  usb_bulk_pkg::endpt_t  blk_endpt_i,
  input  logic                  sof_i,
  input  logic                  crc_err_i,
  input  logic                  timeout_i,
  input  logic                  ack_i,
  input  logic                  s_tvalid_i,
  output logic                  s_tready_o,
  input  logic                  s_tlast_i,
  input  usb_bulk_pkg::byte_t   s_tdata_i,
  output logic                  tx_tvalid_o,
  input  logic                  tx_tready_i,
  output logic                  tx_tlast_o,
  output usb_bulk_pkg::byte_t   tx_tdata_o,
  output logic                  has_telemetry_o
);
  import usb_bulk_pkg::*;

  logic  xfer_start, xfer_tele, tele_start;
  logic  tel_tvalid, tel_tready, tel_tlast;
  byte_t tel_tdata;
  logic  mux_tvalid, mux_tready, mux_tlast;
  byte_t mux_tdata;
  logic  buf_tvalid, buf_tready, buf_tlast;
  byte_t buf_tdata;

  in_endpoint_select u_select (
    .clock(clock), .areset_n(areset_n),
    .blk_start_i(blk_start_i), .blk_endpt_i(blk_endpt_i),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o),
    .s_tlast_i(s_tlast_i), .s_tdata_i(s_tdata_i),
    .tel_tvalid_i(tel_tvalid), .tel_tready_o(tel_tready),
    .tel_tlast_i(tel_tlast), .tel_tdata_i(tel_tdata),
    .mux_tvalid_o(mux_tvalid), .mux_tready_i(mux_tready),
    .mux_tlast_o(mux_tlast), .mux_tdata_o(mux_tdata),
    .xfer_start_o(xfer_start), .xfer_tele_o(xfer_tele), .tele_start_o(tele_start)
  );

  telemetry_capture u_telemetry (
    .clock(clock), .areset_n(areset_n),
    .sof_i(sof_i), .crc_err_i(crc_err_i), .timeout_i(timeout_i),
    .tele_start_i(tele_start),
    .tel_tvalid_o(tel_tvalid), .tel_tready_i(tel_tready),
    .tel_tlast_o(tel_tlast), .tel_tdata_o(tel_tdata),
    .has_telemetry_o(has_telemetry_o)
  );

  axis_skid u_skid (
    .clock(clock), .areset_n(areset_n),
    .s_tvalid_i(mux_tvalid), .s_tready_o(mux_tready),
    .s_tlast_i(mux_tlast), .s_tdata_i(mux_tdata),
    .m_tvalid_o(buf_tvalid), .m_tready_i(buf_tready),
    .m_tlast_o(buf_tlast), .m_tdata_o(buf_tdata)
  );

  data_packetizer u_packetizer (
    .clock(clock), .areset_n(areset_n),
    .xfer_start_i(xfer_start), .xfer_tele_i(xfer_tele), .ack_i(ack_i),
    .s_tvalid_i(buf_tvalid), .s_tready_o(buf_tready),
    .s_tlast_i(buf_tlast), .s_tdata_i(buf_tdata),
    .tx_tvalid_o(tx_tvalid_o), .tx_tready_i(tx_tready_i),
    .tx_tlast_o(tx_tlast_o), .tx_tdata_o(tx_tdata_o)
  );

endmodule

// File: sim/tb_bulk_in_path.sv
module tb_bulk_in_path;
  timeunit 1ns;
  timeprecision 100ps;

  import usb_bulk_pkg::*;

  typedef byte_t byte_q_t[$];

  localparam int unsigned BYTE_CYCLES = 40;  // cycle budget per expected byte

  logic         clock, areset_n;
  logic         blk_start_i;
  endpt_t       blk_endpt_i;
  logic         sof_i, crc_err_i, timeout_i, ack_i;
  logic         s_tvalid_i, s_tready_o, s_tlast_i;
  byte_t        s_tdata_i;
  logic         tx_tvalid_o, tx_tready_i, tx_tlast_o;
  byte_t        tx_tdata_o;
  logic         has_telemetry_o;

  byte_q_t      exp_q;    // expected tx bytes, in order
  logic         last_q[$];  // expected tlast for each of them
  string        test_name;
  int unsigned  cycles, cycle_limit;
  logic         bp_on;  // random tx back-pressure
  logic [2:0]   toggle_ref;  // indexed by endpoint
  endpt_t       last_ep;
  event_count_t sof_ref, crc_ref, tmo_ref;

  bulk_in_path dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("test failed");
      $fatal(1, "timeout, the transmit output stalled after %0d cycles", cycles);
    end
  end

  // sink side ready, randomly dropped while back-pressure is on
  always @(posedge clock) begin
    #1 tx_tready_i = bp_on ? (($urandom % 3) != 0) : 1'b1;
  end

  // usb crc16, one bit at a time lsb first
  function automatic crc16_t crc16_ref(byte_q_t data);
    crc16_t crc;
    logic   fb;
    crc = CRC16_INIT;
    foreach (data[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ data[i][b];
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ CRC16_POLY_REFL;
        end
      end
    end
    return ~crc;
  endfunction

  function automatic byte_q_t frame_ref(endpt_t ep, logic [2:0] toggles, byte_q_t payload);
    byte_q_t frame;
    crc16_t  crc;
    crc   = crc16_ref(payload);
    frame = payload;
    frame.push_front(toggles[ep] ? byte_t'(PID_DATA1) : byte_t'(PID_DATA0));
    frame.push_back(crc[7:0]);  // low byte first
    frame.push_back(crc[15:8]);
    return frame;
  endfunction

  task automatic check_byte(string name, byte_t exp, byte_t act);
    if (act !== exp) begin
      $display("** Error %s: expected byte %h, actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_last(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error %s: expected tlast %b, actual %b", name, exp, act);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("** Error %s: expected flag %b, actual %b", name, exp, act);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // compare every transmitted byte, sampled mid-cycle
  always @(negedge clock) begin
    if (areset_n && tx_tvalid_o && tx_tready_i) begin
      if (exp_q.size() == 0) begin
        $display("** Error %s: byte %h sent while no packet was expected", test_name, tx_tdata_o);
        $display("test failed");
        $fatal(1, "unexpected output byte");
      end else begin
        check_byte(test_name, exp_q.pop_front(), tx_tdata_o);
        check_last(test_name, last_q.pop_front(), tx_tlast_o);
      end
    end
  end

  task automatic step(int unsigned n = 1);
    repeat (n) @(posedge clock);
    #1;
  endtask

  function automatic byte_q_t rand_payload(int unsigned len);
    byte_q_t p;
    repeat (len) p.push_back(byte_t'($urandom));
    return p;
  endfunction

  task automatic expect_packet(endpt_t ep, byte_q_t payload);
    byte_q_t frame;
    frame = frame_ref(ep, toggle_ref, payload);
    foreach (frame[i]) begin
      exp_q.push_back(frame[i]);
      last_q.push_back(i == frame.size() - 1);
    end
    cycle_limit += BYTE_CYCLES * frame.size();
    last_ep = ep;
  endtask

  task automatic start_xfer(endpt_t ep);
    blk_start_i = 1'b1;
    blk_endpt_i = ep;
    step();
    blk_start_i = 1'b0;
  endtask

  task automatic send_user(byte_q_t payload, logic gaps);
    logic taken;
    foreach (payload[i]) begin
      if (gaps) begin
        repeat ($urandom % 3) step();  // idle beats on the user side
      end
      s_tvalid_i = 1'b1;
      s_tdata_i  = payload[i];
      s_tlast_i  = (i == payload.size() - 1);
      do begin
        @(negedge clock);
        taken = s_tready_o;  // registered, stable until the edge
        step();
      end while (!taken);
      s_tvalid_i = 1'b0;
      s_tlast_i  = 1'b0;
    end
  endtask

  task automatic wait_done();
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    step();
  endtask

  task automatic user_packet(int unsigned len, logic gaps);
    byte_q_t p;
    p = rand_payload(len);
    expect_packet(USER_EP, p);
    start_xfer(USER_EP);
    send_user(p, gaps);
    wait_done();
  endtask

  task automatic send_ack();
    ack_i = 1'b1;
    step();
    ack_i = 1'b0;
    toggle_ref[last_ep] = ~toggle_ref[last_ep];
  endtask

  task automatic pulse_events(int unsigned n_sof, int unsigned n_crc, int unsigned n_tmo);
    int unsigned n;
    n = n_sof;
    if (n_crc > n) begin
      n = n_crc;
    end
    if (n_tmo > n) begin
      n = n_tmo;
    end
    cycle_limit += n;
    for (int unsigned i = 0; i < n; i++) begin
      sof_i     = (i < n_sof);
      crc_err_i = (i < n_crc);
      timeout_i = (i < n_tmo);
      step();
    end
    sof_i     = 1'b0;
    crc_err_i = 1'b0;
    timeout_i = 1'b0;
    sof_ref += event_count_t'(n_sof);
    crc_ref += event_count_t'(n_crc);
    tmo_ref += event_count_t'(n_tmo);
  endtask

  task automatic telemetry_packet();
    byte_q_t rec;
    rec = {sof_ref[7:0], sof_ref[15:8], crc_ref[7:0], crc_ref[15:8],
           tmo_ref[7:0], tmo_ref[15:8]};
    expect_packet(TELEMETRY_EP, rec);
    start_xfer(TELEMETRY_EP);
    sof_ref = '0;  // snapshot clears the live counts
    crc_ref = '0;
    tmo_ref = '0;
    @(negedge clock);
    check_flag(test_name, 1'b0, has_telemetry_o);
    wait_done();
  endtask

  initial begin
    void'($urandom(65937));
    areset_n    = 1'b0;
    blk_start_i = 1'b0;
    blk_endpt_i = '0;
    sof_i       = 1'b0;
    crc_err_i   = 1'b0;
    timeout_i   = 1'b0;
    ack_i       = 1'b0;
    s_tvalid_i  = 1'b0;
    s_tlast_i   = 1'b0;
    s_tdata_i   = '0;
    tx_tready_i = 1'b1;
    cycles      = 0;
    cycle_limit = 200;  // reset, idle gaps and handshake slack
    bp_on       = 1'b0;
    toggle_ref  = '0;
    last_ep     = USER_EP;
    sof_ref     = '0;
    crc_ref     = '0;
    tmo_ref     = '0;

    test_name = "reset";
    step(8);
    areset_n = 1'b1;
    @(negedge clock);
    check_flag(test_name, 1'b0, tx_tvalid_o);
    check_flag(test_name, 1'b0, s_tready_o);
    check_flag(test_name, 1'b0, has_telemetry_o);
    step();

    test_name = "user_packet";
    user_packet(1 + $urandom % 20, 1'b0);

    test_name = "toggle_no_ack";  // still DATA0
    user_packet(1 + $urandom % 20, 1'b0);
    send_ack();
    test_name = "toggle_after_ack";
    user_packet(1 + $urandom % 20, 1'b0);

    // endpoint 2 still on DATA0 after the endpoint 1 ack
    test_name = "telemetry";
    pulse_events(1 + $urandom % 20, 1 + $urandom % 20, 1 + $urandom % 20);
    @(negedge clock);
    check_flag(test_name, 1'b1, has_telemetry_o);
    step();
    telemetry_packet();
    test_name = "telemetry_rearm";
    pulse_events(1, 0, 0);
    @(negedge clock);
    check_flag(test_name, 1'b1, has_telemetry_o);
    step();

    test_name = "back_pressure";
    bp_on = 1'b1;
    repeat (4) user_packet(1 + $urandom % 20, 1'b1);
    bp_on = 1'b0;

    test_name = "bad_endpoint";
    start_xfer(4'd5);
    cycle_limit += 16;
    step(16);  // monitor flags any byte here
    test_name = "after_bad_endpoint";
    user_packet(1 + $urandom % 20, 1'b0);

    $display("test passed");
    $finish;
  end

endmodule

// File: sim.f
hdl/usb_bulk_pkg.sv
hdl/in_endpoint_select.sv
hdl/telemetry_capture.sv
hdl/axis_skid.sv
hdl/data_packetizer.sv
hdl/bulk_in_path.sv
sim/tb_bulk_in_path.sv

// File: Bender.yml
package:
  name: usb_bulk_in

sources:
  - hdl/usb_bulk_pkg.sv
  - hdl/in_endpoint_select.sv
  - hdl/telemetry_capture.sv
  - hdl/axis_skid.sv
  - hdl/data_packetizer.sv
  - hdl/bulk_in_path.sv
  - target: simulation
    files:
      - sim/tb_bulk_in_path.sv
